//--- lsq.f
src/lsq_pkg.sv
src/lsq_ifs.sv
src/addr_check.sv
src/op_queue.sv
src/store_buffer.sv
src/issue_select.sv
src/lsq_top.sv
test/lsq_checker.sv
test/tb_lsq.sv

//--- run.sh
#!/bin/sh
# Build the LSQ testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module tb_lsq -f lsq.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/Vtb_lsq); then
    echo "$out"
    echo "Simulation exited with an error"
    exit 1
fi
echo "$out"

if echo "$out" | grep -q "TB PASSED"; then
    exit 0
fi
exit 1

//--- src/addr_check.sv
// Builds the translated copy of the operation offered by the queue and
// picks its exception. Purely combinational
`timescale 1ns/1ns
`default_nettype none

module addr_check import lsq_pkg::*; #(
    parameter logic [XLEN-1:0] MEM_LIMIT = 32'h0010_0000
) (
    xlat_if.check                      xlat,
    input  logic                       translate_en_i,
    input  logic                       tlb_ready_i,
    input  logic                       tlb_miss_i,
    input  logic                       tlb_page_fault_i,
    input  logic [XLEN-PAGE_BITS-1:0]  tlb_ppn_i
);

    mem_op_t         raw;
    mem_op_t         out_op;
    logic [XLEN-1:0] phys_addr;
    logic            done;
    logic            misaligned;
    logic            access_fault;
    logic            page_fault;

    assign raw  = xlat.raw_op;
    assign done = tlb_ready_i & ~tlb_miss_i & raw.valid;

    assign phys_addr = translate_en_i ? {tlb_ppn_i, raw.addr[PAGE_BITS-1:0]} : raw.addr;

    always_comb begin
        case (raw.size)
            HALF:    misaligned = raw.addr[0];
            WORD:    misaligned = |raw.addr[1:0];
            default: misaligned = 1'b0;  // Bytes never misalign
        endcase
    end

    // Physical limit only checked on untranslated accesses
    assign access_fault = ~translate_en_i & (phys_addr >= MEM_LIMIT);
    assign page_fault   = translate_en_i & tlb_page_fault_i;

    always_comb begin
        out_op            = raw;
        out_op.addr       = phys_addr;
        out_op.translated = done;
        out_op.xcpt       = misaligned | access_fault | page_fault;
        if (misaligned) begin
            out_op.cause = raw.is_store ? ST_MISALIGNED : LD_MISALIGNED;
        end else if (access_fault) begin
            out_op.cause = raw.is_store ? ST_ACCESS : LD_ACCESS;
        end else if (page_fault) begin
            out_op.cause = raw.is_store ? ST_PAGE : LD_PAGE;
        end
    end

    assign xlat.xlat_op = out_op;
    assign xlat.done    = done;

endmodule

`default_nettype wire

//--- src/issue_select.sv
// Chooses what the memory stage sees next and turns read_next_i into the
// pop and advance strobes. Also retires head stores into the store buffer
`timescale 1ns/1ns
`default_nettype none

module issue_select import lsq_pkg::*; (
    input  mem_op_t head_i,
    input  logic    head_valid_i,
    sb_if.queue     sb,
    input  logic    read_next_i,
    output mem_op_t next_o,
    output logic    pop_o,
    output logic    sb_write_o,
    output logic    sb_advance_o
);

    logic load_ready;
    logic store_at_head;

    // Loads wait while an older buffered store covers their word
    assign load_ready    = head_valid_i & head_i.translated & ~head_i.is_store & ~sb.collision;
    assign store_at_head = head_valid_i & head_i.is_store;

    always_comb begin
        next_o       = '0;
        pop_o        = 1'b0;
        sb_write_o   = 1'b0;
        sb_advance_o = 1'b0;

        if (load_ready) begin
            next_o = head_i;
            pop_o  = read_next_i;
        end else if (sb.head_op.valid) begin  // Committed oldest store
            next_o       = sb.head_op;
            sb_advance_o = read_next_i;
        end

        // Retirement does not wait for read_next_i
        if (store_at_head && !sb.full) begin
            sb_write_o = 1'b1;
            pop_o      = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/lsq_ifs.sv
// Bundles that link the operation queue with the address checker and with
// the store buffer
`timescale 1ns/1ns
`default_nettype none

interface xlat_if import lsq_pkg::*; ();
    mem_op_t raw_op;   // Incoming op or oldest untranslated entry
    mem_op_t xlat_op;
    logic    done;     // TLB hit on a valid raw op

    modport queue (output raw_op, input xlat_op, input done);
    modport check (input raw_op, output xlat_op, output done);
endinterface

interface sb_if import lsq_pkg::*; ();
    logic    write;    // Retire the queue head into the buffer
    mem_op_t wr_op;
    logic    advance;  // Oldest buffered store was read out
    mem_op_t head_op;  // Valid only once committed
    logic    empty;
    logic    full;
    logic    collision;

    // Head side, also used by the issue logic to see the oldest store
    modport queue (output wr_op, input head_op, input empty, input full, input collision);
    modport buffer (input write, input wr_op, input advance,
                    output head_op, output empty, output full, output collision);
endinterface

`default_nettype wire

//--- src/lsq_pkg.sv
// Widths, size and cause codes, and the queued operation record shared by
// every block of the load/store queue
`default_nettype none

package lsq_pkg;

    parameter int XLEN      = 32;
    parameter int PAGE_BITS = 12;  // 4 KiB pages
    parameter int TAG_W     = 5;

    // Program order tag, matched against the commit stage
    typedef logic [TAG_W-1:0] tag_t;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_e;

    // RISC-V mcause numbering
    typedef enum logic [3:0] {
        LD_MISALIGNED = 4'd4,
        LD_ACCESS     = 4'd5,
        ST_MISALIGNED = 4'd6,
        ST_ACCESS     = 4'd7,
        LD_PAGE       = 4'd13,
        ST_PAGE       = 4'd15
    } cause_e;

    typedef struct packed {
        logic            valid;
        logic            is_store;
        mem_size_e       size;
        logic [XLEN-1:0] addr;        // Virtual until translated
        logic [XLEN-1:0] data;
        tag_t            tag;
        logic            translated;
        logic            xcpt;
        cause_e          cause;       // Only meaningful with xcpt
    } mem_op_t;

endpackage

`default_nettype wire

//--- src/lsq_top.sv
// Load/store queue top level. Plain ports toward the pipeline and the data
// TLB; all logic lives in the submodules
`timescale 1ns/1ns
`default_nettype none

module lsq_top import lsq_pkg::*; #(
    parameter int              NUM_ENTRIES = 8,
    parameter int              SB_ENTRIES  = 4,
    parameter logic [XLEN-1:0] MEM_LIMIT   = 32'h0010_0000
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      flush_i,
    input  logic                      op_valid_i,
    input  logic                      op_store_i,
    input  logic [1:0]                op_size_i,
    input  logic [XLEN-1:0]           op_addr_i,
    input  logic [XLEN-1:0]           op_data_i,
    input  logic [TAG_W-1:0]          op_tag_i,
    input  logic                      translate_en_i,
    output logic                      tlb_req_valid_o,
    output logic [XLEN-PAGE_BITS-1:0] tlb_vpn_o,
    output logic                      tlb_store_o,
    input  logic                      tlb_ready_i,
    input  logic                      tlb_miss_i,
    input  logic [XLEN-PAGE_BITS-1:0] tlb_ppn_i,
    input  logic                      tlb_page_fault_i,
    input  logic                      read_next_i,
    input  logic                      commit_i,
    input  logic [TAG_W-1:0]          commit_tag_i,
    output logic                      next_valid_o,
    output logic                      next_store_o,
    output logic [XLEN-1:0]           next_addr_o,
    output logic [XLEN-1:0]           next_data_o,
    output logic [TAG_W-1:0]          next_tag_o,
    output logic                      next_xcpt_o,
    output logic [3:0]                next_cause_o,
    output logic                      full_o,
    output logic                      empty_o,
    output logic                      collision_o
);

    mem_op_t in_op;
    mem_op_t head_op;
    mem_op_t next_op;
    logic    head_valid;
    logic    pop;
    logic    sb_write;
    logic    sb_advance;

    xlat_if xlat_bus ();
    sb_if   sb_bus ();

    assign in_op = '{
        valid:      op_valid_i,
        is_store:   op_store_i,
        size:       mem_size_e'(op_size_i),
        addr:       op_addr_i,
        data:       op_data_i,
        tag:        op_tag_i,
        translated: 1'b0,
        xcpt:       1'b0,
        cause:      cause_e'(4'd0)
    };

    addr_check #(
        .MEM_LIMIT (MEM_LIMIT)
    ) u_addr_check (
        .xlat             (xlat_bus.check),
        .translate_en_i   (translate_en_i),
        .tlb_ready_i      (tlb_ready_i),
        .tlb_miss_i       (tlb_miss_i),
        .tlb_page_fault_i (tlb_page_fault_i),
        .tlb_ppn_i        (tlb_ppn_i)
    );

    op_queue #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_op_queue (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .flush_i         (flush_i),
        .op_i            (in_op),
        .xlat            (xlat_bus.queue),
        .sb              (sb_bus.queue),
        .pop_i           (pop),
        .head_o          (head_op),
        .head_valid_o    (head_valid),
        .full_o          (full_o),
        .empty_o         (empty_o),
        .tlb_req_valid_o (tlb_req_valid_o)
    );

    store_buffer #(
        .SB_ENTRIES (SB_ENTRIES)
    ) u_store_buffer (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .flush_i      (flush_i),
        .sb           (sb_bus.buffer),
        .commit_i     (commit_i),
        .commit_tag_i (commit_tag_i),
        .load_addr_i  (head_op.addr)
    );

    issue_select u_issue_select (
        .head_i       (head_op),
        .head_valid_i (head_valid),
        .sb           (sb_bus.queue),
        .read_next_i  (read_next_i),
        .next_o       (next_op),
        .pop_o        (pop),
        .sb_write_o   (sb_write),
        .sb_advance_o (sb_advance)
    );

    assign sb_bus.write   = sb_write;
    assign sb_bus.advance = sb_advance;

    assign tlb_vpn_o   = xlat_bus.raw_op.addr[XLEN-1:PAGE_BITS];
    assign tlb_store_o = xlat_bus.raw_op.is_store;

    assign next_valid_o = next_op.valid;
    assign next_store_o = next_op.is_store;
    assign next_addr_o  = next_op.addr;
    assign next_data_o  = next_op.data;
    assign next_tag_o   = next_op.tag;
    assign next_xcpt_o  = next_op.xcpt;
    assign next_cause_o = next_op.cause;
    assign collision_o  = sb_bus.collision;

endmodule

`default_nettype wire

//--- src/op_queue.sv
// Circular table of memory operations in program order. Entries are written
// at the tail, translated in order behind the translate pointer and popped at head
`timescale 1ns/1ns
`default_nettype none

module op_queue import lsq_pkg::*; #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    flush_i,
    input  mem_op_t op_i,
    xlat_if.queue   xlat,
    sb_if.queue     sb,
    input  logic    pop_i,
    output mem_op_t head_o,
    output logic    head_valid_o,
    output logic    full_o,
    output logic    empty_o,
    output logic    tlb_req_valid_o
);

    localparam int PTR_W = $clog2(NUM_ENTRIES);
    localparam int CNT_W = PTR_W + 1;

    mem_op_t          entries [NUM_ENTRIES];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W-1:0] xlat_ptr_q;     // Oldest entry still waiting for the TLB
    logic [CNT_W-1:0] num_to_exe_q;
    logic [CNT_W-1:0] num_to_xlat_q;
    logic [CNT_W:0]   num_total;
    logic             accept;
    logic             xlat_incoming;
    logic             xlat_pending;
    logic             xlat_step;
    mem_op_t          raw_op;

    assign num_total = {1'b0, num_to_exe_q} + {1'b0, num_to_xlat_q};
    assign full_o    = (num_total == (CNT_W+1)'(NUM_ENTRIES)) | flush_i | ~rstn_i;
    assign accept    = op_i.valid & ~full_o;

    // New op goes straight to the TLB only when nothing older is waiting
    assign xlat_pending  = num_to_xlat_q != '0;
    assign xlat_incoming = accept & ~xlat_pending;

    always_comb begin
        raw_op       = xlat_incoming ? op_i : entries[xlat_ptr_q];
        raw_op.valid = xlat_incoming | xlat_pending;
    end

    assign xlat.raw_op     = raw_op;
    assign tlb_req_valid_o = raw_op.valid;
    assign xlat_step       = xlat.done;

    always_ff @(posedge clk_i) begin
        if (accept) begin
            entries[tail_q] <= (xlat_incoming & xlat_step) ? xlat.xlat_op : op_i;
        end
        if (xlat_step & xlat_pending) begin
            entries[xlat_ptr_q] <= xlat.xlat_op;  // Write back the translated copy
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q        <= '0;
            tail_q        <= '0;
            xlat_ptr_q    <= '0;
            num_to_exe_q  <= '0;
            num_to_xlat_q <= '0;
        end else if (flush_i) begin
            head_q        <= '0;
            tail_q        <= '0;
            xlat_ptr_q    <= '0;
            num_to_exe_q  <= '0;
            num_to_xlat_q <= '0;
        end else begin
            head_q        <= head_q + PTR_W'(pop_i);
            tail_q        <= tail_q + PTR_W'(accept);
            xlat_ptr_q    <= xlat_ptr_q + PTR_W'(xlat_step);
            num_to_xlat_q <= num_to_xlat_q + CNT_W'(accept) - CNT_W'(xlat_step);
            num_to_exe_q  <= num_to_exe_q + CNT_W'(xlat_step) - CNT_W'(pop_i);
        end
    end

    assign head_o       = entries[head_q];
    assign head_valid_o = num_to_exe_q != '0;  // Head entry is translated
    assign sb.wr_op     = entries[head_q];
    assign empty_o      = (num_total == '0) & sb.empty;

    // Issue must never overtake the translate pointer
    a_head_behind_xlat: assert property (@(posedge clk_i) disable iff (!rstn_i)
        pop_i |-> num_to_exe_q != '0);

    a_count_bound: assert property (@(posedge clk_i) disable iff (!rstn_i)
        num_total <= (CNT_W+1)'(NUM_ENTRIES));

endmodule

`default_nettype wire

//--- src/store_buffer.sv
// FIFO of stores retired from the queue head. A store leaves only after the
// commit stage names its tag. SB_ENTRIES must be a power of two
`timescale 1ns/1ns
`default_nettype none

module store_buffer import lsq_pkg::*; #(
    parameter int SB_ENTRIES = 4
) (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            flush_i,
    sb_if.buffer            sb,
    input  logic            commit_i,
    input  tag_t            commit_tag_i,
    input  logic [XLEN-1:0] load_addr_i
);

    localparam int PTR_W = $clog2(SB_ENTRIES);
    localparam int CNT_W = PTR_W + 1;

    mem_op_t               stores_q [SB_ENTRIES];
    logic [SB_ENTRIES-1:0] valid_q;
    logic [SB_ENTRIES-1:0] committed_q;
    logic [PTR_W-1:0]      head_q;
    logic [PTR_W-1:0]      tail_q;
    logic [CNT_W-1:0]      count_q;
    logic                  head_commit;
    logic                  hit;
    mem_op_t               head_op;

    always_ff @(posedge clk_i) begin
        if (sb.write) begin
            stores_q[tail_q] <= sb.wr_op;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q     <= '0;
            committed_q <= '0;
            head_q      <= '0;
            tail_q      <= '0;
            count_q     <= '0;
        end else if (flush_i) begin
            valid_q     <= '0;
            committed_q <= '0;
            head_q      <= '0;
            tail_q      <= '0;
            count_q     <= '0;
        end else begin
            for (int i = 0; i < SB_ENTRIES; i++) begin
                if (commit_i && valid_q[i] && stores_q[i].tag == commit_tag_i) begin
                    committed_q[i] <= 1'b1;
                end
            end
            if (sb.advance) begin
                valid_q[head_q]     <= 1'b0;
                committed_q[head_q] <= 1'b0;
                head_q              <= head_q + 1'b1;
            end
            if (sb.write) begin
                valid_q[tail_q]     <= 1'b1;
                // Commit may name the store on the very edge it retires
                committed_q[tail_q] <= commit_i && sb.wr_op.tag == commit_tag_i;
                tail_q              <= tail_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(sb.write) - CNT_W'(sb.advance);
        end
    end

    // Visible in the same cycle the commit arrives
    assign head_commit = valid_q[head_q] &
                         (committed_q[head_q] | (commit_i & (stores_q[head_q].tag == commit_tag_i)));

    always_comb begin
        head_op       = stores_q[head_q];
        head_op.valid = head_commit;
    end

    always_comb begin
        hit = 1'b0;
        for (int i = 0; i < SB_ENTRIES; i++) begin
            if (valid_q[i] && stores_q[i].addr[XLEN-1:2] == load_addr_i[XLEN-1:2]) begin
                hit = 1'b1;  // Same word
            end
        end
    end

    assign sb.head_op   = head_op;
    assign sb.collision = hit;
    assign sb.empty     = count_q == '0;
    assign sb.full      = count_q == CNT_W'(SB_ENTRIES);

    a_no_write_when_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        sb.write |-> !sb.full);

    // Only committed stores may be read out
    a_advance_committed: assert property (@(posedge clk_i) disable iff (!rstn_i)
        sb.advance |-> head_commit);

endmodule

`default_nettype wire

//--- test/lsq_checker.sv
// Watches the LSQ outputs and compares them with the expected items that the
// testbench queues. Prints one line per check and the closing counts
`timescale 1ns/1ns
`default_nettype none

module lsq_checker (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        read_next_i,
    input  logic        next_valid_i,
    input  logic        next_store_i,
    input  logic [31:0] next_addr_i,
    input  logic [31:0] next_data_i,
    input  logic [4:0]  next_tag_i,
    input  logic        next_xcpt_i,
    input  logic [3:0]  next_cause_i,
    input  logic        full_i,
    input  logic        empty_i,
    input  logic        collision_i,
    input  logic        tlb_req_valid_i,
    input  logic [19:0] tlb_vpn_i,
    input  logic        tlb_store_i
);

    int          n_ok = 0;
    int          n_fail = 0;
    string       exp_names [$];
    logic [74:0] exp_items [$];  // {store, addr, data, tag, xcpt, cause}
    string       cur_name;
    logic [74:0] cur_exp;
    logic [74:0] cur_act;

    function automatic string fmt_item(input logic [74:0] item);
        return $sformatf("st=%0d addr=%h data=%h tag=%0d xcpt=%0d cause=%0d",
                         item[74], item[73:42], item[41:10], item[9:5], item[4], item[3:0]);
    endfunction

    function automatic int outstanding();
        return exp_items.size();
    endfunction

    function automatic int failures();
        return n_fail;
    endfunction

    task automatic tally(input string name, input logic good, input string detail);
        if (good) begin
            $display("ok    %s", name);
            n_ok++;
        end else begin
            $display("ERROR %s: %s", name, detail);
            n_fail++;
        end
    endtask

    // Failures outside a value comparison, such as a timeout
    task automatic flag_failure(input string what);
        $display("%s", what);
        n_fail++;
    endtask

    // Cause only counts when an exception is expected
    task automatic expect_item(input string name, input logic st, input logic [31:0] addr,
                               input logic [31:0] data, input logic [4:0] tag,
                               input logic xcpt, input logic [3:0] cause);
        exp_names.push_back(name);
        exp_items.push_back({st, addr, data, tag, xcpt, xcpt ? cause : 4'd0});
    endtask

    // The op on offer this cycle must be the one sent to the TLB
    task automatic check_tlb_req(input string name, input logic [19:0] vpn, input logic st);
        if (!tlb_req_valid_i || tlb_vpn_i != vpn || tlb_store_i != st) begin
            $display("ERROR %s: expected tlb req=1 vpn=%h st=%0d, %s", name, vpn, st,
                     $sformatf("actual tlb req=%0d vpn=%h st=%0d",
                               tlb_req_valid_i, tlb_vpn_i, tlb_store_i));
            n_fail++;
        end
    endtask

    // An item leaves when it is shown while read_next_i is high
    always @(negedge clk_i) begin
        if (rstn_i && next_valid_i && read_next_i) begin
            if (exp_items.size() == 0) begin
                $display("Unexpected output from the queue with tag %0d", next_tag_i);
                n_fail++;
            end else begin
                cur_name = exp_names.pop_front();
                cur_exp  = exp_items.pop_front();
                cur_act  = {next_store_i, next_addr_i, next_data_i, next_tag_i, next_xcpt_i,
                            cur_exp[4] ? next_cause_i : 4'd0};
                tally(cur_name, cur_act == cur_exp, $sformatf("expected %s, actual %s",
                      fmt_item(cur_exp), fmt_item(cur_act)));
            end
        end
    end

    task automatic check_full(input string name, input logic exp_full);
        @(negedge clk_i);
        tally(name, full_i == exp_full,
              $sformatf("expected full_o=%0d, actual full_o=%0d", exp_full, full_i));
    endtask

    task automatic check_flushed(input string name);
        @(negedge clk_i);
        tally(name, empty_i && !next_valid_i,
              $sformatf("expected empty_o=1 next_valid_o=0, actual empty_o=%0d next_valid_o=%0d",
                        empty_i, next_valid_i));
    endtask

    // Load stuck behind an uncommitted store to the same word
    task automatic check_held(input string name, input int cycles);
        int    waited;
        logic  good;
        string detail;
        waited = 0;
        good   = 1'b1;
        detail = "";
        @(negedge clk_i);
        while (!collision_i && waited < 50) begin
            @(negedge clk_i);
            waited++;
        end
        if (!collision_i) begin
            $display("%s: collision_o never rose for the load behind the store", name);
            n_fail++;
        end else begin
            for (int i = 0; i < cycles; i++) begin
                if (good && (!collision_i || next_valid_i)) begin
                    good   = 1'b0;
                    detail = $sformatf("expected collision_o=1 next_valid_o=0, %s",
                                       $sformatf("actual collision_o=%0d next_valid_o=%0d",
                                                 collision_i, next_valid_i));
                end
                @(negedge clk_i);
            end
            tally(name, good, detail);
        end
    endtask

    task automatic report();
        $display("checks: %0d ok, %0d failed", n_ok, n_fail);
    endtask

endmodule

`default_nettype wire

//--- test/lsq_tests.txt
# name kind store size addr xlat_en ppn page_fault tag exp_addr exp_tag exp_xcpt exp_cause
# size 0/1/2 is byte/half/word; on fill lines exp_xcpt is the full_o level after the accept
ld_order_a   op     0 2 00403124 1 12345 0 1  12345124 1  0 0
ld_order_b   op     0 1 00405a3e 1 0abcd 0 2  0abcda3e 2  0 0
ld_order_c   op     0 0 7fff0fff 1 00077 0 3  00077fff 3  0 0
ld_mis_half  op     0 1 00400101 1 00200 1 4  00200101 4  1 4
st_mis_word  op     1 2 00400206 1 00300 0 5  00300206 5  1 6
st_mis_cmt   commit 0 0 00000000 0 00000 0 5  00000000 0  0 0
ld_mis_word  op     0 2 00400002 1 00300 0 6  00300002 6  1 4
ld_access    op     0 2 00100000 0 00000 0 7  00100000 7  1 5
st_access    op     1 0 00123457 0 00000 0 8  00123457 8  1 7
st_acc_cmt   commit 0 0 00000000 0 00000 0 8  00000000 0  0 0
ld_phys_ok   op     0 2 000ffffc 0 00000 0 9  000ffffc 9  0 0
ld_page      op     0 2 00401000 1 00555 1 10 00555000 10 1 13
st_page      op     1 1 00402002 1 00556 1 11 00556002 11 1 15
st_page_cmt  commit 0 0 00000000 0 00000 0 11 00000000 0  0 0
st_hold      op     1 2 00403010 1 00444 0 12 00444010 12 0 0
ld_collide   op     0 0 00403013 1 00444 0 13 00444013 13 0 0
ld_held      hold   0 0 00000000 0 00000 0 0  00000000 0  0 0
st_hold_cmt  commit 0 0 00000000 0 00000 0 12 00000000 0  0 0
fill_0       fill   0 2 00400000 1 00001 0 20 00000000 0  0 0
fill_1       fill   0 2 00401000 1 00001 0 21 00000000 0  0 0
fill_2       fill   0 2 00402000 1 00001 0 22 00000000 0  0 0
fill_3       fill   0 2 00403000 1 00001 0 23 00000000 0  0 0
fill_4       fill   0 2 00404000 1 00001 0 24 00000000 0  0 0
fill_5       fill   0 2 00405000 1 00001 0 25 00000000 0  0 0
fill_6       fill   0 2 00406000 1 00001 0 26 00000000 0  0 0
fill_7       fill   0 2 00407000 1 00001 0 27 00000000 0  1 0
flush_all    flush  0 0 00000000 0 00000 0 0  00000000 0  0 0

//--- test/tb_lsq.sv
// Testbench for the load/store queue. Reads test steps from the data file,
// drives the DUT and answers its TLB requests from the same lines
`timescale 1ns/1ns
`default_nettype none

module tb_lsq;

    localparam int TIMEOUT = 100;  // Cycles allowed for any single wait

    logic        clk;
    logic        rstn;
    logic        flush;
    logic        op_valid;
    logic        op_store;
    logic [1:0]  op_size;
    logic [31:0] op_addr;
    logic [31:0] op_data;
    logic [4:0]  op_tag;
    logic        translate_en;
    logic        tlb_req_valid;
    logic [19:0] tlb_vpn;
    logic        tlb_store;
    logic        tlb_ready;
    logic        tlb_miss;
    logic [19:0] tlb_ppn;
    logic        tlb_page_fault;
    logic        read_next;
    logic        commit;
    logic [4:0]  commit_tag;
    logic        next_valid;
    logic        next_store;
    logic [31:0] next_addr;
    logic [31:0] next_data;
    logic [4:0]  next_tag;
    logic        next_xcpt;
    logic [3:0]  next_cause;
    logic        full;
    logic        empty;
    logic        collision;

    lsq_top DUT (
        .clk_i            (clk),
        .rstn_i           (rstn),
        .flush_i          (flush),
        .op_valid_i       (op_valid),
        .op_store_i       (op_store),
        .op_size_i        (op_size),
        .op_addr_i        (op_addr),
        .op_data_i        (op_data),
        .op_tag_i         (op_tag),
        .translate_en_i   (translate_en),
        .tlb_req_valid_o  (tlb_req_valid),
        .tlb_vpn_o        (tlb_vpn),
        .tlb_store_o      (tlb_store),
        .tlb_ready_i      (tlb_ready),
        .tlb_miss_i       (tlb_miss),
        .tlb_ppn_i        (tlb_ppn),
        .tlb_page_fault_i (tlb_page_fault),
        .read_next_i      (read_next),
        .commit_i         (commit),
        .commit_tag_i     (commit_tag),
        .next_valid_o     (next_valid),
        .next_store_o     (next_store),
        .next_addr_o      (next_addr),
        .next_data_o      (next_data),
        .next_tag_o       (next_tag),
        .next_xcpt_o      (next_xcpt),
        .next_cause_o     (next_cause),
        .full_o           (full),
        .empty_o          (empty),
        .collision_o      (collision)
    );

    lsq_checker chk (
        .clk_i           (clk),
        .rstn_i          (rstn),
        .read_next_i     (read_next),
        .next_valid_i    (next_valid),
        .next_store_i    (next_store),
        .next_addr_i     (next_addr),
        .next_data_i     (next_data),
        .next_tag_i      (next_tag),
        .next_xcpt_i     (next_xcpt),
        .next_cause_i    (next_cause),
        .full_i          (full),
        .empty_i         (empty),
        .collision_i     (collision),
        .tlb_req_valid_i (tlb_req_valid),
        .tlb_vpn_i       (tlb_vpn),
        .tlb_store_i     (tlb_store)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Holds the op until an edge with full_o low takes it and checks its TLB request
    task automatic push(input string name, input logic rd, input logic st,
                        input logic [1:0] sz, input logic [31:0] addr, input logic xen,
                        input logic [19:0] ppn, input logic pf, input logic [4:0] tag);
        int cycles;
        cycles = 0;
        @(posedge clk);
        read_next      <= rd;
        op_valid       <= 1'b1;
        op_store       <= st;
        op_size        <= sz;
        op_addr        <= addr;
        op_data        <= ~addr;
        op_tag         <= tag;
        translate_en   <= xen;
        tlb_ppn        <= ppn;  // TLB answer for this op
        tlb_page_fault <= pf;
        @(negedge clk);
        while (full && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (full) begin
            chk.flag_failure("Timeout: full_o never dropped while an op was offered");
        end else begin
            chk.check_tlb_req(name, addr[31:12], st);
        end
        @(posedge clk);  // Accept edge
        op_valid <= 1'b0;
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (chk.outstanding() != 0 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (chk.outstanding() != 0) begin
            chk.flag_failure("Timeout: expected operations never left the queue");
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        string       name;
        string       kind;
        logic        st;
        logic [1:0]  sz;
        logic [31:0] addr;
        logic        xen;
        logic [19:0] ppn;
        logic        pf;
        logic [4:0]  tag;
        logic [31:0] exp_addr;
        logic [4:0]  exp_tag;
        logic        exp_x;
        logic [3:0]  exp_cause;

        rstn           = 1'b0;
        flush          = 1'b0;
        op_valid       = 1'b0;
        op_store       = 1'b0;
        op_size        = 2'd0;
        op_addr        = '0;
        op_data        = '0;
        op_tag         = '0;
        translate_en   = 1'b0;
        tlb_ready      = 1'b1;  // TLB always answers with a hit or a fault
        tlb_miss       = 1'b0;
        tlb_ppn        = '0;
        tlb_page_fault = 1'b0;
        read_next      = 1'b1;
        commit         = 1'b0;
        commit_tag     = '0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;

        fd = $fopen("test/lsq_tests.txt", "r");
        if (fd == 0) begin
            chk.flag_failure("Could not open test/lsq_tests.txt");
        end
        while (fd != 0 && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n <= 1 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %s %d %d %h %d %h %d %d %h %d %d %d", name, kind, st, sz,
                        addr, xen, ppn, pf, tag, exp_addr, exp_tag, exp_x, exp_cause);
            if (n != 13) begin
                chk.flag_failure($sformatf("Malformed line in test data: %s", line));
                continue;
            end
            case (kind)
                "op": begin
                    chk.expect_item(name, st, exp_addr, ~addr, exp_tag, exp_x, exp_cause);
                    push(name, 1'b1, st, sz, addr, xen, ppn, pf, tag);
                end
                "fill": begin
                    drain();
                    push(name, 1'b0, st, sz, addr, xen, ppn, pf, tag);
                    chk.check_full(name, exp_x);  // exp_x holds the full_o level
                end
                "commit": begin
                    @(posedge clk);
                    commit     <= 1'b1;
                    commit_tag <= tag;
                    drain();
                end
                "hold": chk.check_held(name, 4);
                "flush": begin
                    @(posedge clk);
                    flush <= 1'b1;
                    @(posedge clk);
                    flush <= 1'b0;
                    chk.check_flushed(name);
                end
                default: chk.flag_failure($sformatf("Unknown step kind %s in test data", kind));
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        drain();
        chk.report();
        if (chk.failures() == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
